// File: mips_exec_top.f
rtl/mips_pkg.sv
rtl/instr_queue.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/alu.sv
rtl/exec_core.sv
rtl/mips_exec_top.sv
test/tb_mips_exec.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status follows the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mips_exec_top.f --top-module tb_mips_exec \
	-o sim_tb_mips_exec
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb_mips_exec
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit $status
fi
exit 0

// File: test/tb_mips_exec.sv
`timescale 1ns/1ps

module tb_mips_exec;

	localparam int QUEUE_DEPTH = 4;
	localparam int RESULT_CREDITS = 4;
	localparam logic [31:0] SEED = 32'hc9b3_e844;

	logic clk;
	logic rst;
	logic instr_valid;
	logic [31:0] instr;
	logic result_credit;
	logic instr_credit;
	logic res_valid;
	logic res_write;
	logic [4:0] res_reg;
	logic [31:0] res_data;
	logic res_illegal;

	string names[$];
	logic [31:0] words[$];
	logic [31:0] exp_data[$];
	int exp_write[$];
	int exp_reg[$];
	int exp_illegal[$];
	int return_due[$]; // Cycle at which each result credit goes back

	int cycle_count = 0;
	int timeout_limit = 1000;
	int sender_credits = QUEUE_DEPTH;
	int consumer_credits = RESULT_CREDITS;
	int next_push = 0;
	int beats_seen = 0;
	int pick;

	mips_exec_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .RESULT_CREDITS(RESULT_CREDITS)) mips_exec_top_inst (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr),
		.result_credit(result_credit), .instr_credit(instr_credit), .res_valid(res_valid),
		.res_write(res_write), .res_reg(res_reg), .res_data(res_data), .res_illegal(res_illegal)
	);

	always #5 clk = ~clk;

	task automatic stop_on_error(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
			stop_on_error("run stopped on a wrong value");
		end
	endtask

	function automatic logic [31:0] r_type(input int rs, input int rt, input int rd,
		input int sh, input int funct);
		return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(funct)};
	endfunction

	function automatic logic [31:0] i_type(input int op, input int rs, input int rt, input int imm);
		return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	task automatic add_test(input string name, input logic [31:0] word, input int wr, input int rg,
		input logic [31:0] data, input int ill);
		names.push_back(name);
		words.push_back(word);
		exp_write.push_back(wr);
		exp_reg.push_back(rg);
		exp_data.push_back(data);
		exp_illegal.push_back(ill);
	endtask

	task automatic build_table();
		add_test("reset_read", r_type(2, 3, 1, 0, 'h21), 1, 1, 32'h0000_0000, 0);
		add_test("addiu_neg", i_type('h09, 0, 1, 'hfffb), 1, 1, 32'hffff_fffb, 0);
		add_test("slti", i_type('h0a, 1, 2, 'hfffc), 1, 2, 32'h0000_0001, 0);
		add_test("sltiu", i_type('h0b, 1, 3, 'hfffc), 1, 3, 32'h0000_0001, 0); // Sign-extended imm
		add_test("ori_zext", i_type('h0d, 0, 4, 'h8001), 1, 4, 32'h0000_8001, 0);
		add_test("andi_zext", i_type('h0c, 1, 5, 'h8f0f), 1, 5, 32'h0000_8f0b, 0);
		add_test("xori_zext", i_type('h0e, 1, 6, 'h8000), 1, 6, 32'hffff_7ffb, 0);
		add_test("lui", i_type('h0f, 0, 7, 'h1234), 1, 7, 32'h1234_0000, 0);
		add_test("addu", r_type(7, 4, 8, 0, 'h21), 1, 8, 32'h1234_8001, 0);
		add_test("subu", r_type(8, 2, 9, 0, 'h23), 1, 9, 32'h1234_8000, 0);
		add_test("and", r_type(9, 5, 10, 0, 'h24), 1, 10, 32'h0000_8000, 0);
		add_test("or", r_type(10, 7, 11, 0, 'h25), 1, 11, 32'h1234_8000, 0);
		add_test("xor", r_type(11, 6, 12, 0, 'h26), 1, 12, 32'hedcb_fffb, 0);
		add_test("nor", r_type(12, 0, 13, 0, 'h27), 1, 13, 32'h1234_0004, 0);
		add_test("sll", r_type(0, 13, 14, 4, 'h00), 1, 14, 32'h2340_0040, 0);
		add_test("srl", r_type(0, 14, 15, 8, 'h02), 1, 15, 32'h0023_4000, 0);
		add_test("slt", r_type(12, 15, 16, 0, 'h2a), 1, 16, 32'h0000_0001, 0);
		add_test("sltu", r_type(12, 15, 17, 0, 'h2b), 1, 17, 32'h0000_0000, 0);
		add_test("mult", r_type(1, 6, 0, 0, 'h18), 0, 0, 32'h0002_8019, 0); // -5 * -32773
		add_test("multu", r_type(1, 6, 0, 0, 'h19), 0, 0, 32'h0002_8019, 0);
		add_test("mfhi_prod", r_type(0, 0, 18, 0, 'h10), 1, 18, 32'hffff_7ff6, 0);
		add_test("mflo_prod", r_type(0, 0, 19, 0, 'h12), 1, 19, 32'h0002_8019, 0);
		add_test("mthi", r_type(7, 0, 0, 0, 'h11), 0, 0, 32'h1234_0000, 0);
		add_test("mtlo", r_type(8, 0, 0, 0, 'h13), 0, 0, 32'h1234_8001, 0);
		add_test("mfhi_moved", r_type(0, 0, 20, 0, 'h10), 1, 20, 32'h1234_0000, 0);
		add_test("mflo_moved", r_type(0, 0, 21, 0, 'h12), 1, 21, 32'h1234_8001, 0);
		add_test("bad_opcode", i_type('h3f, 1, 4, 'h1111), 0, 0, 32'h0000_0000, 1);
		add_test("bad_funct", r_type(1, 1, 4, 0, 'h3f), 0, 0, 32'h0000_0000, 1);
		add_test("r4_kept", r_type(4, 0, 22, 0, 'h25), 1, 22, 32'h0000_8001, 0);
		add_test("write_r0", i_type('h09, 7, 0, 'h0001), 1, 0, 32'h1234_0001, 0);
		add_test("r0_zero", r_type(0, 0, 23, 0, 'h25), 1, 23, 32'h0000_0000, 0);
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_limit) begin
			stop_on_error("timeout: not every result beat arrived in time");
		end
	end

	initial begin
		void'($urandom(SEED));
		clk = 1'b0;
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		result_credit = 1'b0;
		build_table();
		timeout_limit = 40 * names.size() + 100;
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;
		repeat (3) begin // Idle after reset
			@(negedge clk);
			check_value("reset res_valid", 32'h0, 32'(res_valid));
			check_value("reset instr_credit", 32'h0, 32'(instr_credit));
		end
		@(posedge clk);
		#1;
		while (beats_seen < names.size()) begin
			pick = -1;
			foreach (return_due[i]) begin
				if (pick < 0 && return_due[i] <= cycle_count) pick = i;
			end
			result_credit = (pick >= 0);
			if (pick >= 0) begin
				return_due.delete(pick);
				consumer_credits++;
			end
			instr_valid = (next_push < names.size()) && (sender_credits > 0);
			if (instr_valid) begin
				instr = words[next_push];
				next_push++;
				sender_credits--;
			end
			@(negedge clk);
			if (instr_credit) begin
				sender_credits++;
				if (sender_credits > QUEUE_DEPTH) stop_on_error("more credits than queue entries");
			end
			if (res_valid) begin
				if (consumer_credits == 0) stop_on_error("more result beats than credits granted");
				consumer_credits--;
				check_value({names[beats_seen], " res_illegal"}, 32'(exp_illegal[beats_seen]),
					32'(res_illegal));
				check_value({names[beats_seen], " res_write"}, 32'(exp_write[beats_seen]),
					32'(res_write));
				if (exp_write[beats_seen] != 0) begin
					check_value({names[beats_seen], " res_reg"}, 32'(exp_reg[beats_seen]),
						32'(res_reg));
				end
				check_value({names[beats_seen], " res_data"}, exp_data[beats_seen], res_data);
				return_due.push_back(cycle_count + int'($urandom % 32'd4)); // 0 to 3 cycles
				beats_seen++;
			end
			@(posedge clk);
			#1;
		end
		instr_valid = 1'b0;
		result_credit = 1'b0;
		repeat (4) begin
			@(negedge clk);
			check_value("no extra beat", 32'h0, 32'(res_valid));
		end
		check_value("sender credits restored", 32'(QUEUE_DEPTH), 32'(sender_credits));
		$display("All tests passed");
		$finish;
	end

endmodule

// File: rtl/mips_exec_top.sv
`timescale 1ns/1ps

module mips_exec_top #(
	parameter int QUEUE_DEPTH = 4,
	parameter int RESULT_CREDITS = 4
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            instr_valid,
	input  logic [mips_pkg::DATA_W-1:0]     instr,
	input  logic                            result_credit,
	output logic                            instr_credit,
	output logic                            res_valid,
	output logic                            res_write,
	output logic [mips_pkg::REG_ADDR_W-1:0] res_reg,
	output logic [mips_pkg::DATA_W-1:0]     res_data,
	output logic                            res_illegal
);

	logic q_valid;
	logic [mips_pkg::DATA_W-1:0] q_instr;
	logic q_pop;

	instr_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) instr_queue_inst (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr), .q_pop(q_pop),
		.q_valid(q_valid), .q_instr(q_instr), .instr_credit(instr_credit)
	);

	exec_core #(.RESULT_CREDITS(RESULT_CREDITS)) exec_core_inst (
		.clk(clk), .rst(rst), .q_valid(q_valid), .q_instr(q_instr),
		.result_credit(result_credit), .q_pop(q_pop), .res_valid(res_valid),
		.res_write(res_write), .res_reg(res_reg), .res_data(res_data), .res_illegal(res_illegal)
	);

endmodule

// File: rtl/exec_core.sv
`timescale 1ns/1ps

module exec_core #(
	parameter int RESULT_CREDITS = 4
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            q_valid,
	input  logic [mips_pkg::DATA_W-1:0]     q_instr,
	input  logic                            result_credit,
	output logic                            q_pop,
	output logic                            res_valid,
	output logic                            res_write,
	output logic [mips_pkg::REG_ADDR_W-1:0] res_reg,
	output logic [mips_pkg::DATA_W-1:0]     res_data,
	output logic                            res_illegal
);

	localparam int CNT_W = $clog2(RESULT_CREDITS + 1);

	logic [CNT_W-1:0] credit_cnt;
	logic iss_valid;
	logic [mips_pkg::DATA_W-1:0] iss_instr;
	logic register_write;
	logic alu_src_imm;
	mips_pkg::reg_dst_e register_destination;
	mips_pkg::alu_op_e alu_op;
	logic hi_write;
	logic lo_write;
	logic no_sign_extend;
	logic illegal;
	logic [mips_pkg::DATA_W-1:0] read_data_a;
	logic [mips_pkg::DATA_W-1:0] read_data_b;
	logic [mips_pkg::DATA_W-1:0] imm_ext;
	logic [mips_pkg::DATA_W-1:0] alu_result;
	logic [2*mips_pkg::DATA_W-1:0] product;
	logic [mips_pkg::DATA_W-1:0] hi;
	logic [mips_pkg::DATA_W-1:0] lo;
	logic [mips_pkg::REG_ADDR_W-1:0] dest;
	logic is_mult;

	assign q_pop = q_valid && (credit_cnt != '0);

	assign imm_ext = no_sign_extend ? {16'h0000, iss_instr[15:0]}
		: {{16{iss_instr[15]}}, iss_instr[15:0]};
	assign dest = (register_destination == mips_pkg::DST_RD) ? iss_instr[15:11] : iss_instr[20:16];
	assign is_mult = (alu_op == mips_pkg::ALU_MULT) || (alu_op == mips_pkg::ALU_MULTU);

	control_unit control_unit_inst (
		.instruction(iss_instr), .register_write(register_write), .alu_src_imm(alu_src_imm),
		.register_destination(register_destination), .alu_op(alu_op), .hi_write(hi_write),
		.lo_write(lo_write), .no_sign_extend(no_sign_extend), .illegal(illegal)
	);

	register_file register_file_inst (
		.clk(clk), .rst(rst), .read_addr_a(iss_instr[25:21]), .read_addr_b(iss_instr[20:16]),
		.write_enable(iss_valid && register_write), .write_addr(dest), .write_data(alu_result),
		.read_data_a(read_data_a), .read_data_b(read_data_b)
	);

	alu alu_inst (
		.alu_op(alu_op), .operand_a(read_data_a), .operand_b(alu_src_imm ? imm_ext : read_data_b),
		.shamt(iss_instr[10:6]), .hi(hi), .lo(lo), .result(alu_result), .product(product)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			credit_cnt <= CNT_W'(RESULT_CREDITS);
			iss_valid <= 1'b0;
			hi <= '0;
			lo <= '0;
			res_valid <= 1'b0;
			res_write <= 1'b0;
			res_illegal <= 1'b0;
		end else begin
			if (q_pop && !result_credit) begin
				credit_cnt <= credit_cnt - 1'b1;
			end else if (!q_pop && result_credit) begin
				credit_cnt <= credit_cnt + 1'b1;
			end
			iss_valid <= q_pop;
			if (iss_valid && hi_write) begin
				hi <= is_mult ? product[2*mips_pkg::DATA_W-1:mips_pkg::DATA_W] : read_data_a;
			end
			if (iss_valid && lo_write) begin
				lo <= is_mult ? product[mips_pkg::DATA_W-1:0] : read_data_a;
			end
			res_valid <= iss_valid;
			res_write <= iss_valid && register_write;
			res_illegal <= iss_valid && illegal;
		end
	end

	always_ff @(posedge clk) begin
		if (q_pop) begin
			iss_instr <= q_instr;
		end
		res_reg <= dest;
		res_data <= illegal ? '0 : alu_result; // Illegal beats carry zero
	end

	a_credit_range: assert property (@(posedge clk) disable iff (rst)
		credit_cnt <= CNT_W'(RESULT_CREDITS));
	// A presented beat still holds the credit it spent
	a_beat_has_credit: assert property (@(posedge clk) disable iff (rst)
		res_valid |-> (int'(credit_cnt) + int'(iss_valid) < RESULT_CREDITS));

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
	input  mips_pkg::alu_op_e             alu_op,
	input  logic [mips_pkg::DATA_W-1:0]   operand_a,
	input  logic [mips_pkg::DATA_W-1:0]   operand_b,
	input  logic [4:0]                    shamt,
	input  logic [mips_pkg::DATA_W-1:0]   hi,
	input  logic [mips_pkg::DATA_W-1:0]   lo,
	output logic [mips_pkg::DATA_W-1:0]   result,
	output logic [2*mips_pkg::DATA_W-1:0] product
);

	logic signed [2*mips_pkg::DATA_W-1:0] product_s;
	logic [2*mips_pkg::DATA_W-1:0] product_u;

	assign product_s = $signed(operand_a) * $signed(operand_b);
	assign product_u = {{mips_pkg::DATA_W{1'b0}}, operand_a}
		* {{mips_pkg::DATA_W{1'b0}}, operand_b};
	assign product = (alu_op == mips_pkg::ALU_MULTU) ? product_u : product_s;

	always_comb begin
		case (alu_op)
			mips_pkg::ALU_ADD:     result = operand_a + operand_b;
			mips_pkg::ALU_SUB:     result = operand_a - operand_b;
			mips_pkg::ALU_AND:     result = operand_a & operand_b;
			mips_pkg::ALU_OR:      result = operand_a | operand_b;
			mips_pkg::ALU_XOR:     result = operand_a ^ operand_b;
			mips_pkg::ALU_NOR:     result = ~(operand_a | operand_b);
			mips_pkg::ALU_SLT: begin
				result = {{(mips_pkg::DATA_W-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
			end
			mips_pkg::ALU_SLTU: begin
				result = {{(mips_pkg::DATA_W-1){1'b0}}, operand_a < operand_b};
			end
			mips_pkg::ALU_SLL:     result = operand_b << shamt; // Shifts act on rt
			mips_pkg::ALU_SRL:     result = operand_b >> shamt;
			mips_pkg::ALU_LUI:     result = {operand_b[15:0], 16'h0000};
			mips_pkg::ALU_MULT,
			mips_pkg::ALU_MULTU:   result = product[mips_pkg::DATA_W-1:0]; // New LO
			mips_pkg::ALU_PASS_A:  result = operand_a;
			mips_pkg::ALU_PASS_HI: result = hi;
			mips_pkg::ALU_PASS_LO: result = lo;
			default:               result = '0;
		endcase
	end

endmodule

// File: rtl/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [mips_pkg::REG_ADDR_W-1:0] read_addr_a,
	input  logic [mips_pkg::REG_ADDR_W-1:0] read_addr_b,
	input  logic                            write_enable,
	input  logic [mips_pkg::REG_ADDR_W-1:0] write_addr,
	input  logic [mips_pkg::DATA_W-1:0]     write_data,
	output logic [mips_pkg::DATA_W-1:0]     read_data_a,
	output logic [mips_pkg::DATA_W-1:0]     read_data_b
);

	localparam int NUM_REGS = 1 << mips_pkg::REG_ADDR_W;

	logic [mips_pkg::DATA_W-1:0] regs [NUM_REGS];

	assign read_data_a = regs[read_addr_a];
	assign read_data_b = regs[read_addr_b];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable && (write_addr != '0)) begin // r0 stays zero
			regs[write_addr] <= write_data;
		end
	end

endmodule

// File: rtl/control_unit.sv
`timescale 1ns/1ps

module control_unit (
	input  logic [mips_pkg::DATA_W-1:0] instruction,
	output logic                        register_write,
	output logic                        alu_src_imm,
	output mips_pkg::reg_dst_e          register_destination,
	output mips_pkg::alu_op_e           alu_op,
	output logic                        hi_write,
	output logic                        lo_write,
	output logic                        no_sign_extend,
	output logic                        illegal
);

	logic [5:0] op;
	logic [5:0] funct;

	assign op = instruction[31:26];
	assign funct = instruction[5:0];

	always_comb begin
		register_write = 1'b0;
		alu_src_imm = 1'b0;
		register_destination = mips_pkg::DST_RT;
		alu_op = mips_pkg::ALU_ADD;
		hi_write = 1'b0;
		lo_write = 1'b0;
		no_sign_extend = 1'b0;
		illegal = 1'b0;
		case (op)
			mips_pkg::OP_SPECIAL: begin
				register_destination = mips_pkg::DST_RD;
				register_write = 1'b1;
				case (funct)
					mips_pkg::F_ADDU:  alu_op = mips_pkg::ALU_ADD;
					mips_pkg::F_SUBU:  alu_op = mips_pkg::ALU_SUB;
					mips_pkg::F_AND:   alu_op = mips_pkg::ALU_AND;
					mips_pkg::F_OR:    alu_op = mips_pkg::ALU_OR;
					mips_pkg::F_XOR:   alu_op = mips_pkg::ALU_XOR;
					mips_pkg::F_NOR:   alu_op = mips_pkg::ALU_NOR;
					mips_pkg::F_SLT:   alu_op = mips_pkg::ALU_SLT;
					mips_pkg::F_SLTU:  alu_op = mips_pkg::ALU_SLTU;
					mips_pkg::F_SLL:   alu_op = mips_pkg::ALU_SLL;
					mips_pkg::F_SRL:   alu_op = mips_pkg::ALU_SRL;
					mips_pkg::F_MFHI:  alu_op = mips_pkg::ALU_PASS_HI;
					mips_pkg::F_MFLO:  alu_op = mips_pkg::ALU_PASS_LO;
					mips_pkg::F_MULT, mips_pkg::F_MULTU: begin
						register_write = 1'b0;
						hi_write = 1'b1;
						lo_write = 1'b1;
						alu_op = (funct == mips_pkg::F_MULT) ? mips_pkg::ALU_MULT
							: mips_pkg::ALU_MULTU;
					end
					mips_pkg::F_MTHI, mips_pkg::F_MTLO: begin
						register_write = 1'b0;
						hi_write = (funct == mips_pkg::F_MTHI);
						lo_write = (funct == mips_pkg::F_MTLO);
						alu_op = mips_pkg::ALU_PASS_A; // rs goes straight through
					end
					default: begin
						register_write = 1'b0;
						illegal = 1'b1;
					end
				endcase
			end
			mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU, mips_pkg::OP_ANDI,
			mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
				register_write = 1'b1;
				alu_src_imm = 1'b1;
				case (op)
					mips_pkg::OP_SLTI:  alu_op = mips_pkg::ALU_SLT;
					mips_pkg::OP_SLTIU: alu_op = mips_pkg::ALU_SLTU; // Still sign-extended
					mips_pkg::OP_ANDI:  alu_op = mips_pkg::ALU_AND;
					mips_pkg::OP_ORI:   alu_op = mips_pkg::ALU_OR;
					mips_pkg::OP_XORI:  alu_op = mips_pkg::ALU_XOR;
					mips_pkg::OP_LUI:   alu_op = mips_pkg::ALU_LUI;
					default:            alu_op = mips_pkg::ALU_ADD;
				endcase
				no_sign_extend = (op == mips_pkg::OP_ANDI) || (op == mips_pkg::OP_ORI)
					|| (op == mips_pkg::OP_XORI);
			end
			default: begin
				illegal = 1'b1;
			end
		endcase
	end

endmodule

// File: rtl/instr_queue.sv
`timescale 1ns/1ps

module instr_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        instr_valid,
	input  logic [mips_pkg::DATA_W-1:0] instr,
	input  logic                        q_pop,
	output logic                        q_valid,
	output logic [mips_pkg::DATA_W-1:0] q_instr,
	output logic                        instr_credit
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	logic [mips_pkg::DATA_W-1:0] mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign q_valid = (count != '0);
	assign q_instr = mem[rd_ptr];
	assign instr_credit = q_pop; // One credit back per pop

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			mem[wr_ptr] <= instr;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (instr_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (q_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (instr_valid && !q_pop) begin
				count <= count + 1'b1;
			end else if (!instr_valid && q_pop) begin
				count <= count - 1'b1;
			end
		end
	end

	// Sender must hold a credit for every push
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		instr_valid |-> (count < CNT_W'(QUEUE_DEPTH)));
	a_no_underflow: assert property (@(posedge clk) disable iff (rst) q_pop |-> q_valid);

endmodule

// File: rtl/mips_pkg.sv
package mips_pkg;

	localparam int DATA_W = 32; // Fixed by the ISA
	localparam int REG_ADDR_W = 5;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111
	} opcode_e;

	typedef enum logic [5:0] {
		F_SLL   = 6'b000000,
		F_SRL   = 6'b000010,
		F_MFHI  = 6'b010000,
		F_MTHI  = 6'b010001,
		F_MFLO  = 6'b010010,
		F_MTLO  = 6'b010011,
		F_MULT  = 6'b011000,
		F_MULTU = 6'b011001,
		F_ADDU  = 6'b100001,
		F_SUBU  = 6'b100011,
		F_AND   = 6'b100100,
		F_OR    = 6'b100101,
		F_XOR   = 6'b100110,
		F_NOR   = 6'b100111,
		F_SLT   = 6'b101010,
		F_SLTU  = 6'b101011
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU,
		ALU_SLL, ALU_SRL, ALU_LUI, ALU_MULT, ALU_MULTU, ALU_PASS_A, ALU_PASS_HI, ALU_PASS_LO
	} alu_op_e;

	typedef enum logic {
		DST_RT = 1'b0,
		DST_RD = 1'b1
	} reg_dst_e;

endpackage
